// ==== dv/rhChk.sv ====
module rhChk (
   input logic              clk,
   input logic              rst,
   input logic              devReset,
   input logic              devHiByte,
   input logic              devLoByte,
   input logic              iack,
   input logic              intReq,
   input logic              cs1Write,
   input rhPkg::rhWriteWord wrData,
   input logic              goWrite,
   input logic              startOk,
   input logic              rhClr,
   input logic [7:0]        errFlags,
   input logic              rpGo,
   input logic              rpAta,
   input logic              rpErr,
   input logic [4:0]        rpFun,
   input logic              cs1Rdy,
   input logic              cs1Ie,
   input logic              cs1Sc,
   input logic [15:0]       cs1Word,
   input logic [15:0]       cs2Word,
   input logic [1:0]        baExt
);
   timeunit 1ns;
   timeprecision 1ps;
   import rhPkg::*;

   int   failCount = 0;
   logic treStat;

   // Same error source that feeds TRE
   assign treStat = (|errFlags) | rpErr;

   task automatic noteFail(input string name);
      failCount++;
      $error("assertion %s did not hold", name);
   endtask

   //////////////////////////////
   // Drive function
   //////////////////////////////

   // Accepted start loads GO and FUN
   startLoad: assert property (@(posedge clk) disable iff (rst)
      startOk && !devReset |=> rpGo && rpFun == $past(wrData.cs1.fun))
      else noteFail("startLoad");
   // Fixed busy time, attention with the falling GO
   busyTime: assert property (@(posedge clk) disable iff (rst)
      $fell(rpGo) |-> rpAta && $past(rpGo, DRIVE_BUSY_CYCLES)
         && !$past(rpGo, DRIVE_BUSY_CYCLES + 1))
      else noteFail("busyTime");
   pgeSet: assert property (@(posedge clk) disable iff (rst)
      goWrite && rpGo && !devReset |=> errFlags[CS2_PGE - CS2_DPE])
      else noteFail("pgeSet");
   // Idle drive but rejected, so the unit was wrong
   nedSet: assert property (@(posedge clk) disable iff (rst)
      goWrite && !rpGo && !startOk && !devReset |=> errFlags[CS2_NED - CS2_DPE] && !rpGo)
      else noteFail("nedSet");

   //////////////////////////////
   // TRE and write gating
   //////////////////////////////

   treRise: assert property (@(posedge clk) disable iff (rst)
      $rose(treStat) && !goWrite && !devReset && !rhClr |=> cs1Word[CS1_TRE] && cs1Sc
         && cs1Word[CS1_SC])
      else noteFail("treRise");
   // A held error gives one edge only
   treOnce: assert property (@(posedge clk) disable iff (rst)
      $rose(cs1Word[CS1_TRE]) |-> $past(treStat) && !$past(treStat, 2))
      else noteFail("treOnce");
   treClr: assert property (@(posedge clk) disable iff (rst)
      goWrite |=> !cs1Word[CS1_TRE])
      else noteFail("treClr");
   busyHold: assert property (@(posedge clk) disable iff (rst)
      cs1Write && devHiByte && !cs1Rdy && !devReset |=> $stable(baExt)
         && $stable(cs1Word[CS1_PSEL]))
      else noteFail("busyHold");
   readyTake: assert property (@(posedge clk) disable iff (rst)
      cs1Write && devHiByte && cs1Rdy && !devReset |=> baExt == $past(wrData.cs1.ba)
         && cs1Word[CS1_PSEL] == $past(wrData.cs1.psel))
      else noteFail("readyTake");

   //////////////////////////////
   // Interrupts and clears
   //////////////////////////////

   ieRaise: assert property (@(posedge clk) disable iff (rst)
      cs1Write && devLoByte && wrData.cs1.ie && cs1Rdy && !iack && !devReset |=> intReq)
      else noteFail("ieRaise");
   doneRaise: assert property (@(posedge clk) disable iff (rst)
      $rose(cs1Rdy) && cs1Ie && !iack && !devReset && !rhClr |=> intReq)
      else noteFail("doneRaise");
   ackDrop: assert property (@(posedge clk) disable iff (rst)
      iack |=> !intReq && !cs1Ie)
      else noteFail("ackDrop");
   // Both clears land on the reset values
   clearAll: assert property (@(posedge clk) disable iff (rst)
      devReset || rhClr |=> !intReq && !cs1Ie && !rpGo && !rpAta && errFlags == '0
         && baExt == '0 && cs2Word[CS2_UNIT_HI:CS2_UNIT_LO] == '0
         && !cs1Word[CS1_PSEL] && !cs1Word[CS1_TRE])
      else noteFail("clearAll");

endmodule

bind rhController rhChk uChk (.*);

// ==== dv/rhTb.sv ====
module rhTb;
   timeunit 1ns;
   timeprecision 1ps;
   import rhPkg::*;

   logic              clk = 1'b0;
   logic              rst;
   logic              devReset;
   logic              devWrite;
   logic [1:0]        devAddr;
   logic              devLoByte;
   logic              devHiByte;
   logic [0:DATA_W-1] devDataI;
   logic [0:DATA_W-1] devDataO;
   logic [ERR_W-1:0]  errSet;
   logic              driveFault;
   logic              driveOnline;
   logic              iack;
   logic              intReq;
   int                errCount = 0;
   int                timeouts = 0;
   int                bitSel;
   rhWriteWord        w;
   logic [4:0]        fun;
   logic [1:0]        baVal;

   // 4 ns clock
   always #2 clk = ~clk;

   rhController dut (.*);

   // Advance n edges, land 1 ns after the last one
   task automatic step(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic writeReg(input logic [1:0] addr, input logic lo, input logic hi,
                           input logic [15:0] data);
      devAddr   = addr;
      devLoByte = lo;
      devHiByte = hi;
      devDataI  = {{(DATA_W - 16){1'b0}}, data};
      devWrite  = 1'b1;
      step(1);
      devWrite  = 1'b0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
   endtask

   // Combinational read, upper bus bits must stay zero
   task automatic checkReg(input string name, input logic [1:0] addr,
                           input logic [15:0] mask, input logic [15:0] expected);
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] want;
      devAddr = addr;
      #1;
      got  = devDataO & {{(DATA_W - 16){1'b1}}, mask};
      want = {{(DATA_W - 16){1'b0}}, expected & mask};
      if (got !== want)
      begin
         errCount++;
         $display("[ERROR] %s expected %h actual %h", name, want, got);
      end
      step(1);
   endtask

   task automatic checkLevel(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         errCount++;
         $display("[ERROR] %s expected %b actual %b", name, expected, actual);
      end
   endtask

   // Poll RDY once per cycle
   task automatic waitReady(input string name);
      logic [15:0] rd;
      int          n;
      n       = 0;
      devAddr = REG_CS1;
      #1;
      rd = devDataO[20:DATA_W-1];
      while (!rd[CS1_RDY] && n < 4 * DRIVE_BUSY_CYCLES)
      begin
         step(1);
         #1;
         rd = devDataO[20:DATA_W-1];
         n++;
      end
      if (!rd[CS1_RDY])
      begin
         timeouts++;
         $display("Timed out in %s waiting for the drive to become ready", name);
      end
      step(1);
   endtask

   task automatic startGo(input logic [4:0] f);
      rhWriteWord g;
      g        = '0;
      g.cs1.fun = f;
      g.cs1.go = 1'b1;
      writeReg(REG_CS1, 1'b1, 1'b0, g);
   endtask

   task automatic pulseAck();
      iack = 1'b1;
      step(1);
      iack = 1'b0;
   endtask

   // IE, PSEL, BA, errors and unit all away from reset
   task automatic dirtyState();
      rhWriteWord g;
      g        = '0;
      g.cs1.ie = 1'b1;
      g.cs1.psel = 1'b1;
      g.cs1.ba = 2'b11;
      writeReg(REG_CS1, 1'b1, 1'b1, g);
      errSet = ERR_W'($urandom_range(255, 1));
      step(1);
      errSet = '0;
      g = '0;
      g.cs2.unit = 3'd2;
      writeReg(REG_CS2, 1'b1, 1'b0, g);
      step(1);
   endtask

   task automatic checkCleared(input string name);
      checkReg({name, "Cs1"}, REG_CS1, 16'hC7C1, 16'h0080);
      checkReg({name, "Cs2"}, REG_CS2, 16'hFFFF, 16'h0000);
      checkLevel({name, "Intr"}, 1'b0, intReq);
   endtask

   initial
   begin
      void'($urandom(66));
      rst         = 1'b1;
      devReset    = 1'b0;
      devWrite    = 1'b0;
      devAddr     = REG_CS1;
      devLoByte   = 1'b0;
      devHiByte   = 1'b0;
      devDataI    = '0;
      errSet      = '0;
      driveFault  = 1'b0;
      driveOnline = 1'b1;
      iack        = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      step(1);
      checkCleared("reset");

      // Start and completion
      fun = 5'($urandom);
      startGo(fun);
      checkReg("startCs1", REG_CS1, 16'h00FF, {8'h00, 1'b0, 1'b0, fun, 1'b1});
      waitReady("completion");
      checkReg("doneCs1", REG_CS1, 16'hA881, 16'h8880);
      checkReg("doneDs", REG_DS, 16'hC081, 16'h8080);
      checkReg("unusedAddr", 2'd3, 16'hFFFF, 16'h0000);

      // Transfer error from a random strobe
      bitSel = $urandom_range(ERR_W - 1, 0);
      errSet = ERR_W'(1) << bitSel;
      step(1);
      errSet = '0;
      checkReg("errFlag", REG_CS2, 16'hFF00, 16'(1 << (CS2_DPE + bitSel)));
      step(1);
      checkReg("treSet", REG_CS1, 16'hC000, 16'hC000);
      startGo(5'($urandom));
      checkReg("treGoClr", REG_CS1, 16'h4000, 16'h0000);
      checkReg("errGoClr", REG_CS2, 16'hFF00, 16'h0000);
      waitReady("treStart");
      // Held fault, one TRE only
      driveFault = 1'b1;
      step(2);
      checkReg("faultTre", REG_CS1, 16'h4000, 16'h4000);
      checkReg("faultDs", REG_DS, 16'h4000, 16'h4000);
      startGo(5'($urandom));
      waitReady("faultStart");
      checkReg("faultHeld", REG_CS1, 16'h4000, 16'h0000);
      driveFault = 1'b0;
      step(1);

      // Rejected starts
      startGo(5'($urandom));
      startGo(5'($urandom));
      checkReg("pgeSet", REG_CS2, 16'h0400, 16'h0400);
      waitReady("pgeStart");
      w = '0;
      w.cs2.unit = 3'd3;
      writeReg(REG_CS2, 1'b1, 1'b0, w);
      startGo(5'($urandom));
      checkReg("nedSet", REG_CS2, 16'h1000, 16'h1000);
      checkReg("nedNoGo", REG_CS1, 16'h0001, 16'h0000);
      w = '0;
      writeReg(REG_CS2, 1'b1, 1'b0, w);

      // PSEL and BA gating
      baVal = 2'($urandom);
      w = '0;
      w.cs1.psel = 1'b1;
      w.cs1.ba = baVal;
      writeReg(REG_CS1, 1'b0, 1'b1, w);
      checkReg("readyTake", REG_CS1, 16'h0700, {5'd0, 1'b1, baVal, 8'h00});
      startGo(5'($urandom));
      w.cs1.psel = 1'b0;
      w.cs1.ba = ~baVal;
      writeReg(REG_CS1, 1'b0, 1'b1, w);
      checkReg("busyHold", REG_CS1, 16'h0700, {5'd0, 1'b1, baVal, 8'h00});
      waitReady("gateStart");

      // Interrupts
      w = '0;
      w.cs1.ie = 1'b1;
      writeReg(REG_CS1, 1'b1, 1'b0, w);
      checkLevel("ieIntr", 1'b1, intReq);
      pulseAck();
      checkLevel("ackIntr", 1'b0, intReq);
      checkReg("ackIe", REG_CS1, 16'h0040, 16'h0000);
      startGo(5'($urandom));
      writeReg(REG_CS1, 1'b1, 1'b0, w);
      waitReady("intrStart");
      step(1);
      checkLevel("doneIntr", 1'b1, intReq);
      pulseAck();
      checkLevel("doneAck", 1'b0, intReq);

      // CS2 CLR, unit field ignored
      dirtyState();
      w = '0;
      w.cs2.clr = 1'b1;
      w.cs2.unit = 3'd5;
      writeReg(REG_CS2, 1'b1, 1'b0, w);
      checkCleared("clr");
      dirtyState();
      devReset = 1'b1;
      step(1);
      devReset = 1'b0;
      checkCleared("devReset");
      step(4);

      $display("Errors: %0d read checks, %0d assertions, %0d timeouts",
               errCount, dut.uChk.failCount, timeouts);
      if (errCount == 0 && dut.uChk.failCount == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== logic/rhController.sv ====
module rhController (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     devReset,
   input  logic                     devWrite,
   input  logic [1:0]               devAddr,
   input  logic                     devLoByte,
   input  logic                     devHiByte,
   input  logic [0:rhPkg::DATA_W-1] devDataI,
   input  logic [rhPkg::ERR_W-1:0]  errSet,
   input  logic                     driveFault,
   input  logic                     driveOnline,
   input  logic                     iack,
   output logic [0:rhPkg::DATA_W-1] devDataO,
   output logic                     intReq
);
   import rhPkg::*;

   logic [DATA_W-1:0] dataLe;
   logic [DATA_W-1:0] rdLe;
   rhWriteWord        wrData;
   logic              cs1Write, cs2Write;
   logic              rhClr, goWrite, startOk;
   logic [ERR_W-1:0]  errFlags;
   logic              cs1Rdy, cs1Ie, cs1Sc;
   logic [15:0]       cs1Word, cs2Word, dsWord, rdWord;
   logic              rpGo, rpAta, rpErr, rpDva;
   logic [4:0]        rpFun;
   logic [1:0]        baExt;

   ///////////////////////////////
   // Write decode
   ///////////////////////////////

   // Bus bit 0 is the MSB, flip to bit 35
   assign dataLe   = devDataI;
   assign wrData   = dataLe[15:0];
   assign cs1Write = devWrite & (devAddr == REG_CS1);
   assign cs2Write = devWrite & (devAddr == REG_CS2);

   // Bus address bits 17:16, held only while idle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         baExt <= 2'd0;
      else if (devReset | rhClr)
         baExt <= 2'd0;
      else if (cs1Write & devHiByte & cs1Rdy)
         baExt <= wrData.cs1.ba;
   end

   rhCs1 uCs1 (.clk, .rst, .devReset, .rhClr, .cs1Write, .loByte(devLoByte),
      .hiByte(devHiByte), .wrData, .errFlags, .iack, .rpAta, .rpErr, .rpDva, .rpGo,
      .rpFun, .baExt, .goWrite, .cs1Rdy, .cs1Ie, .cs1Sc, .cs1Word);

   rhCs2 uCs2 (.clk, .rst, .devReset, .cs2Write, .loByte(devLoByte), .hiByte(devHiByte),
      .wrData, .errSet, .goWrite, .rpGo, .rhClr, .errFlags, .startOk, .cs2Word);

   rpDrive uDrive (.clk, .rst, .devReset, .rhClr, .goWrite, .startOk, .wrData,
      .driveFault, .driveOnline, .rpGo, .rpAta, .rpErr, .rpDva, .rpFun);

   rhIntr uIntr (.clk, .rst, .devReset, .rhClr, .cs1Write, .loByte(devLoByte), .wrData,
      .cs1Rdy, .cs1Ie, .iack, .intReq);

   ///////////////////////////////
   // Read path
   ///////////////////////////////

   // Drive 0 status
   always_comb
   begin
      dsWord          = '0;
      dsWord[DS_ATA]  = rpAta;
      dsWord[DS_ERR]  = rpErr;
      dsWord[DS_DVA]  = rpDva;
      dsWord[DS_BUSY] = rpGo;
   end

   always_comb
   begin
      case (devAddr)
         REG_CS1: rdWord = cs1Word;
         REG_CS2: rdWord = cs2Word;
         REG_DS:  rdWord = dsWord;
         default: rdWord = 16'h0000;
      endcase
   end

   // Upper 20 bits zero, back to bus order
   assign rdLe     = {{(DATA_W - 16){1'b0}}, rdWord};
   assign devDataO = rdLe;

endmodule

// ==== logic/rhCs1.sv ====
module rhCs1 (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    devReset,
   input  logic                    rhClr,
   input  logic                    cs1Write,
   input  logic                    loByte,
   input  logic                    hiByte,
   input  rhPkg::rhWriteWord       wrData,
   input  logic [rhPkg::ERR_W-1:0] errFlags,
   input  logic                    iack,
   input  logic                    rpAta,
   input  logic                    rpErr,
   input  logic                    rpDva,
   input  logic                    rpGo,
   input  logic [4:0]              rpFun,
   input  logic [1:0]              baExt,
   output logic                    goWrite,
   output logic                    cs1Rdy,
   output logic                    cs1Ie,
   output logic                    cs1Sc,
   output logic [15:0]             cs1Word
);
   import rhPkg::*;

   logic treStat;
   logic treLast;
   logic tre;
   logic psel;

   // GO write is seen in the write cycle itself
   assign goWrite = cs1Write & loByte & wrData.cs1.go;

   ///////////////////////////////
   // Transfer error
   ///////////////////////////////

   // Any controller error or drive composite error
   assign treStat = (|errFlags) | rpErr;

   // TRE only on the rising edge, a held error sets it once
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         treLast <= 1'b0;
         tre     <= 1'b0;
      end
      else
      begin
         treLast <= treStat;
         if (devReset | rhClr | goWrite)
            tre <= 1'b0;
         else if (treStat & ~treLast)
            tre <= 1'b1;
      end
   end

   ///////////////////////////////
   // PSEL and IE
   ///////////////////////////////

   // PSEL frozen while a function runs
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         psel  <= 1'b0;
         cs1Ie <= 1'b0;
      end
      else
      begin
         if (devReset | rhClr)
            psel <= 1'b0;
         else if (cs1Write & hiByte & cs1Rdy)
            psel <= wrData.cs1.psel;
         // Acknowledge also drops the enable
         if (devReset | rhClr | iack)
            cs1Ie <= 1'b0;
         else if (cs1Write & loByte)
            cs1Ie <= wrData.cs1.ie;
      end
   end

   assign cs1Rdy = ~rpGo;
   assign cs1Sc  = tre | rpAta;

   // Read view of CS1
   always_comb
   begin
      cs1Word                        = '0;
      cs1Word[CS1_SC]                = cs1Sc;
      cs1Word[CS1_TRE]               = tre;
      // No Massbus control parity in this model
      cs1Word[CS1_CPE]               = 1'b0;
      cs1Word[CS1_DVA]               = rpDva;
      cs1Word[CS1_PSEL]              = psel;
      cs1Word[CS1_BA_HI:CS1_BA_LO]   = baExt;
      cs1Word[CS1_RDY]               = cs1Rdy;
      cs1Word[CS1_IE]                = cs1Ie;
      // FUN and GO come back from the drive
      cs1Word[CS1_FUN_HI:CS1_FUN_LO] = rpFun;
      cs1Word[CS1_GO]                = rpGo;
   end

endmodule

// ==== logic/rhCs2.sv ====
module rhCs2 (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    devReset,
   input  logic                    cs2Write,
   input  logic                    loByte,
   input  logic                    hiByte,
   input  rhPkg::rhWriteWord       wrData,
   input  logic [rhPkg::ERR_W-1:0] errSet,
   input  logic                    goWrite,
   input  logic                    rpGo,
   output logic                    rhClr,
   output logic [rhPkg::ERR_W-1:0] errFlags,
   output logic                    startOk,
   output logic [15:0]             cs2Word
);
   import rhPkg::*;

   logic [2:0]       unitSel;
   logic [ERR_W-1:0] setVec;

   // Controller clear pulse straight from the write
   assign rhClr = cs2Write & loByte & wrData.cs2.clr;

   // Only unit 0 exists, and only an idle drive takes a function
   assign startOk = goWrite & (unitSel == 3'd0) & ~rpGo;

   ///////////////////////////////
   // Error flags
   ///////////////////////////////

   // Strobes from the data path plus start rejections
   always_comb
   begin
      setVec = errSet;
      setVec[CS2_NED - CS2_DPE] = setVec[CS2_NED - CS2_DPE] | (goWrite & (unitSel != 3'd0));
      setVec[CS2_PGE - CS2_DPE] = setVec[CS2_PGE - CS2_DPE] | (goWrite & rpGo);
      // UPE and MXF can be forced from the high byte for diagnostics
      if (cs2Write & hiByte)
      begin
         setVec[CS2_UPE - CS2_DPE] = setVec[CS2_UPE - CS2_DPE] | wrData.cs2.err[CS2_UPE - CS2_DPE];
         setVec[CS2_MXF - CS2_DPE] = setVec[CS2_MXF - CS2_DPE] | wrData.cs2.err[CS2_MXF - CS2_DPE];
      end
   end

   // Sticky until clear or an accepted start
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         errFlags <= '0;
      else if (devReset | rhClr)
         errFlags <= '0;
      else if (startOk)
         errFlags <= setVec;
      else
         errFlags <= errFlags | setVec;
   end

   // Unit select, CLR wins over the written value
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         unitSel <= 3'd0;
      else if (devReset | rhClr)
         unitSel <= 3'd0;
      else if (cs2Write & loByte)
         unitSel <= wrData.cs2.unit;
   end

   // Read view of CS2
   always_comb
   begin
      cs2Word                          = '0;
      cs2Word[CS2_DLT]                 = errFlags[CS2_DLT - CS2_DPE];
      cs2Word[CS2_WCE]                 = errFlags[CS2_WCE - CS2_DPE];
      cs2Word[CS2_UPE]                 = errFlags[CS2_UPE - CS2_DPE];
      cs2Word[CS2_NED]                 = errFlags[CS2_NED - CS2_DPE];
      cs2Word[CS2_NEM]                 = errFlags[CS2_NEM - CS2_DPE];
      cs2Word[CS2_PGE]                 = errFlags[CS2_PGE - CS2_DPE];
      cs2Word[CS2_MXF]                 = errFlags[CS2_MXF - CS2_DPE];
      cs2Word[CS2_DPE]                 = errFlags[0];
      // CLR is a pulse and reads back as zero
      cs2Word[CS2_CLR]                 = 1'b0;
      cs2Word[CS2_UNIT_HI:CS2_UNIT_LO] = unitSel;
   end

endmodule

// ==== logic/rhIntr.sv ====
module rhIntr (
   input  logic              clk,
   input  logic              rst,
   input  logic              devReset,
   input  logic              rhClr,
   input  logic              cs1Write,
   input  logic              loByte,
   input  rhPkg::rhWriteWord wrData,
   input  logic              cs1Rdy,
   input  logic              cs1Ie,
   input  logic              iack,
   output logic              intReq
);
   import rhPkg::*;

   logic rdyLast;
   logic rdyRise;
   logic ieSetRdy;

   // Completion edge with interrupts on
   assign rdyRise  = cs1Rdy & ~rdyLast & cs1Ie;
   // Software enables IE on an idle controller
   assign ieSetRdy = cs1Write & loByte & wrData.cs1.ie & cs1Rdy;

   // Request held until acknowledged
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdyLast <= 1'b1;
         intReq  <= 1'b0;
      end
      else
      begin
         rdyLast <= cs1Rdy;
         if (devReset | rhClr | iack)
            intReq <= 1'b0;
         else if (rdyRise | ieSetRdy)
            intReq <= 1'b1;
      end
   end

endmodule

// ==== logic/rhPkg.sv ====
package rhPkg;

   // Device bus width
   localparam int DATA_W = 36;

   // Register addresses, address 3 reads as zero
   localparam logic [1:0] REG_CS1 = 2'd0;
   localparam logic [1:0] REG_CS2 = 2'd1;
   localparam logic [1:0] REG_DS  = 2'd2;

   // CS1 bit positions
   localparam int CS1_SC = 15, CS1_TRE = 14, CS1_CPE = 13, CS1_DVA = 11, CS1_PSEL = 10;
   localparam int CS1_BA_HI = 9, CS1_BA_LO = 8, CS1_RDY = 7, CS1_IE = 6;
   localparam int CS1_FUN_HI = 5, CS1_FUN_LO = 1, CS1_GO = 0;

   // CS2 bit positions
   localparam int CS2_DLT = 15, CS2_WCE = 14, CS2_UPE = 13, CS2_NED = 12, CS2_NEM = 11;
   localparam int CS2_PGE = 10, CS2_MXF = 9, CS2_DPE = 8, CS2_CLR = 5;
   localparam int CS2_UNIT_HI = 2, CS2_UNIT_LO = 0;

   // Drive status bit positions
   localparam int DS_ATA = 15, DS_ERR = 14, DS_DVA = 7, DS_BUSY = 0;

   // Drive function time in clocks
   localparam int DRIVE_BUSY_CYCLES = 8;
   localparam int BUSY_CNT_W = $clog2(DRIVE_BUSY_CYCLES + 1);

   // CS2 error flags, DLT at the top
   localparam int ERR_W = 8;

   // One write word, two register views
   typedef union packed {
      struct packed {
         logic       sc;
         logic       tre;
         logic       cpe;
         logic       rsvd12;
         logic       dva;
         logic       psel;
         logic [1:0] ba;
         logic       rdy;
         logic       ie;
         logic [4:0] fun;
         logic       go;
      } cs1;
      struct packed {
         logic [7:0] err;
         logic [1:0] rsvd7;
         logic       clr;
         logic [1:0] rsvd4;
         logic [2:0] unit;
      } cs2;
   } rhWriteWord;

endpackage

// ==== logic/rpDrive.sv ====
module rpDrive (
   input  logic              clk,
   input  logic              rst,
   input  logic              devReset,
   input  logic              rhClr,
   input  logic              goWrite,
   input  logic              startOk,
   input  rhPkg::rhWriteWord wrData,
   input  logic              driveFault,
   input  logic              driveOnline,
   output logic              rpGo,
   output logic              rpAta,
   output logic              rpErr,
   output logic              rpDva,
   output logic [4:0]        rpFun
);
   import rhPkg::*;

   logic [BUSY_CNT_W-1:0] busyCnt;
   logic                  start;

   assign start = goWrite & startOk;

   ///////////////////////////////
   // Function timer
   ///////////////////////////////

   // GO high for DRIVE_BUSY_CYCLES clocks, then attention
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rpGo    <= 1'b0;
         rpAta   <= 1'b0;
         rpFun   <= 5'd0;
         busyCnt <= '0;
      end
      else if (devReset | rhClr)
      begin
         // Massbus init aborts the function
         rpGo    <= 1'b0;
         rpAta   <= 1'b0;
         busyCnt <= '0;
      end
      else if (start)
      begin
         rpFun   <= wrData.cs1.fun;
         rpGo    <= 1'b1;
         rpAta   <= 1'b0;
         busyCnt <= BUSY_CNT_W'(DRIVE_BUSY_CYCLES);
      end
      else if (rpGo)
      begin
         // Last busy cycle
         if (busyCnt == BUSY_CNT_W'(1))
         begin
            rpGo  <= 1'b0;
            rpAta <= 1'b1;
         end
         busyCnt <= busyCnt - BUSY_CNT_W'(1);
      end
   end

   // Composite error only from a drive that is there
   assign rpErr = driveFault & driveOnline;
   assign rpDva = driveOnline;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module rhTb -f sim.f -o rhSim \
   && ./obj_dir/rhSim +verilator+error+limit+100 | tee sim.log \
   || echo "build or simulation stopped with an error"
# Pass only when the testbench printed its pass line
grep -qx "TEST PASSED" sim.log 2>/dev/null || exit 1
exit 0

// ==== sim.f ====
logic/rhPkg.sv
logic/rhCs1.sv
logic/rhCs2.sv
logic/rpDrive.sv
logic/rhIntr.sv
logic/rhController.sv
dv/rhChk.sv
dv/rhTb.sv
